// ==== armBusPkg.sv ====
package armBusPkg;

   localparam int dataWidth    = 32;
   localparam int addrWidth    = 32;
   localparam int regAddrWidth = 4;

   // Requesters on the shared memory port
   localparam int numRequesters = 2;
   localparam int reqIdWidth    = $clog2(numRequesters);
   localparam int reqFetch      = 0;
   localparam int reqData       = 1;

endpackage

// ==== armCore.sv ====
`timescale 1ns/1ps

module armCore (
   input  logic                           clk,
   input  logic                           reset,
   output logic                           memValid,
   input  logic                           memReady,
   output logic [armBusPkg::addrWidth-1:0] memAddr,
   output logic                           memWrite,
   output logic [armBusPkg::dataWidth-1:0] memWdata,
   input  logic [armBusPkg::dataWidth-1:0] memRdata
);
   import armIsaPkg::*;
   import armBusPkg::*;

   logic                 fetchValid, fetchReady;
   logic [addrWidth-1:0] fetchAddr;
   logic                 dataValid, dataReady, dataWrite, dataDone;
   logic [addrWidth-1:0] dataAddr, dataAddrIn;
   logic [dataWidth-1:0] dataWdata, storeData;
   instrWord_u           instr;
   logic [addrWidth-1:0] pc, branchTarget;
   logic                 memReq, memStore, pcLoad, retire;
   logic                 regWrite, aluSrcImm, resultFromMem;
   logic [2:0]           aluOp;
   logic [1:0]           immSel;
   logic [3:0]           aluFlags;

   fetchUnit i_fetchUnit (
      .clk(clk), .reset(reset),
      .fetchValid(fetchValid), .fetchAddr(fetchAddr), .fetchReady(fetchReady),
      .memRdata(memRdata), .instr(instr), .pc(pc),
      .memReq(memReq), .dataDone(dataDone),
      .pcLoad(pcLoad), .branchTarget(branchTarget), .retire(retire));

   loadStoreUnit i_loadStoreUnit (
      .clk(clk), .reset(reset),
      .memReq(memReq), .memStore(memStore),
      .dataAddrIn(dataAddrIn), .storeData(storeData),
      .dataValid(dataValid), .dataAddr(dataAddr), .dataWrite(dataWrite),
      .dataWdata(dataWdata), .dataReady(dataReady), .dataDone(dataDone));

   memArbiter i_memArbiter (
      .clk(clk), .reset(reset),
      .fetchValid(fetchValid), .fetchAddr(fetchAddr),
      .dataValid(dataValid), .dataAddr(dataAddr),
      .dataWrite(dataWrite), .dataWdata(dataWdata),
      .fetchReady(fetchReady), .dataReady(dataReady),
      .memValid(memValid), .memReady(memReady), .memAddr(memAddr),
      .memWrite(memWrite), .memWdata(memWdata));

   instrDecoder i_instrDecoder (
      .clk(clk), .reset(reset),
      .instr(instr), .aluFlags(aluFlags), .retire(retire),
      .regWrite(regWrite), .memReq(memReq), .memStore(memStore),
      .aluSrcImm(aluSrcImm), .aluOp(aluOp), .immSel(immSel),
      .resultFromMem(resultFromMem), .pcLoad(pcLoad));

   execDatapath i_execDatapath (
      .clk(clk), .reset(reset),
      .instr(instr), .pc(pc), .retire(retire), .regWrite(regWrite),
      .aluSrcImm(aluSrcImm), .aluOp(aluOp), .immSel(immSel),
      .resultFromMem(resultFromMem), .memRdata(memRdata),
      .aluFlags(aluFlags), .dataAddrIn(dataAddrIn),
      .storeData(storeData), .branchTarget(branchTarget));

endmodule

// ==== armCore_assertions.sv ====
`timescale 1ns/1ps

module armCore_assertions (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            memValid,
   input  logic                            memReady,
   input  logic [armBusPkg::addrWidth-1:0] memAddr,
   input  logic                            memWrite,
   input  logic [armBusPkg::dataWidth-1:0] memWdata
);

   int failCount = 0;

   // Request fields frozen until ready
   holdRequest: assert property (@(posedge clk) disable iff (reset)
      memValid && !memReady |=> memValid && $stable(memAddr) &&
                                $stable(memWrite) && $stable(memWdata))
      else begin
         failCount++;
         $error("Bus request dropped or changed while waiting for ready");
      end

   quietInReset: assert property (@(posedge clk) reset |-> !memValid && !memWrite)
      else begin
         failCount++;
         $error("Bus active during reset");
      end

endmodule

// ==== armCore_stimulus.txt ====
// Records: kind addr write data; kind 1 program word, 2 data preload
// kind 3 expected transfer in order (write 1 = store data, 0 = read value)
1 00 0 E2801012  1 04 0 E2802034  1 08 0 E0813002  1 0C 0 E5803100
1 10 0 E2434005  1 14 0 E0035002  1 18 0 E381600F  1 1C 0 E0267002
1 20 0 E5804104  1 24 0 E5805108  1 28 0 E580610C  1 2C 0 E5807110
1 30 0 E0438001  1 34 0 E22190FF  1 38 0 E206A00C  1 3C 0 E5808114
1 40 0 E5809118  1 44 0 E580A11C  1 48 0 E3510012  1 4C 0 05803120
1 50 0 15804124  1 54 0 E211B080  1 58 0 25806128  1 5C 0 E250C001
1 60 0 4580C12C  1 64 0 25801130  1 68 0 B5809134  1 6C 0 E5901200
1 70 0 E5902204  1 74 0 E0813002  1 78 0 E5801138  1 7C 0 E580313C
1 80 0 EA000002  1 90 0 E280F0A0  1 A0 0 E580F140  1 A4 0 EAFFFFFE
2 200 0 CAFEF00D  2 204 0 13572468
3 00 0 E2801012  3 04 0 E2802034  3 08 0 E0813002  3 0C 0 E5803100
3 100 1 00000046  3 10 0 E2434005  3 14 0 E0035002  3 18 0 E381600F
3 1C 0 E0267002  3 20 0 E5804104  3 104 1 00000041  3 24 0 E5805108
3 108 1 00000004  3 28 0 E580610C  3 10C 1 0000001F  3 2C 0 E5807110
3 110 1 0000002B  3 30 0 E0438001  3 34 0 E22190FF  3 38 0 E206A00C
3 3C 0 E5808114  3 114 1 00000034  3 40 0 E5809118  3 118 1 000000ED
3 44 0 E580A11C  3 11C 1 0000000C  3 48 0 E3510012  3 4C 0 05803120
3 120 1 00000046  3 50 0 15804124  3 54 0 E211B080  3 58 0 25806128
3 128 1 0000001F  3 5C 0 E250C001  3 60 0 4580C12C  3 12C 1 FFFFFFFF
3 64 0 25801130  3 68 0 B5809134  3 134 1 000000ED  3 6C 0 E5901200
3 200 0 CAFEF00D  3 70 0 E5902204  3 204 0 13572468  3 74 0 E0813002
3 78 0 E5801138  3 138 1 CAFEF00D  3 7C 0 E580313C  3 13C 1 DE561475
3 80 0 EA000002  3 90 0 E280F0A0  3 A0 0 E580F140  3 140 1 000000A8
3 A4 0 EAFFFFFE  3 A4 0 EAFFFFFE

// ==== armIsaPkg.sv ====
package armIsaPkg;

   // One instruction word, three decodings
   typedef union packed {
      struct packed {
         logic [3:0]  cond;
         logic [1:0]  op;
         logic        immFlag;   // 1 for imm8 operand
         logic [3:0]  opcode;
         logic        sBit;      // Update NZCV
         logic [3:0]  rn;
         logic [3:0]  rd;
         logic [11:0] operand;   // imm8 or {8'b0, rm}
      } dp;
      struct packed {
         logic [3:0]  cond;
         logic [1:0]  op;
         logic [4:0]  puBW;      // Fixed I, P, U, B, W bits
         logic        load;      // 1 = LDR, 0 = STR
         logic [3:0]  rn;
         logic [3:0]  rd;
         logic [11:0] imm12;
      } mem;
      struct packed {
         logic [3:0]  cond;
         logic [1:0]  op;
         logic        brFlag;    // Always 1 for B
         logic        link;      // BL not supported
         logic [23:0] imm24;
      } br;
   } instrWord_u;

   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory   = 2'b01;
   localparam logic [1:0] opBranch   = 2'b10;

   // Data-processing opcodes, bits 24:21
   localparam logic [3:0] dpAnd = 4'b0000;
   localparam logic [3:0] dpEor = 4'b0001;
   localparam logic [3:0] dpSub = 4'b0010;
   localparam logic [3:0] dpAdd = 4'b0100;
   localparam logic [3:0] dpCmp = 4'b1010;
   localparam logic [3:0] dpOrr = 4'b1100;

   localparam logic [2:0] aluAdd = 3'd0;
   localparam logic [2:0] aluSub = 3'd1;
   localparam logic [2:0] aluAnd = 3'd2;
   localparam logic [2:0] aluOrr = 3'd3;
   localparam logic [2:0] aluEor = 3'd4;

   localparam logic [1:0] immSel8      = 2'd0;
   localparam logic [1:0] immSel12     = 2'd1;
   localparam logic [1:0] immSelBranch = 2'd2;

   localparam logic [3:0] condEq     = 4'b0000;
   localparam logic [3:0] condNe     = 4'b0001;
   localparam logic [3:0] condCs     = 4'b0010;
   localparam logic [3:0] condCc     = 4'b0011;
   localparam logic [3:0] condMi     = 4'b0100;
   localparam logic [3:0] condPl     = 4'b0101;
   localparam logic [3:0] condVs     = 4'b0110;
   localparam logic [3:0] condVc     = 4'b0111;
   localparam logic [3:0] condHi     = 4'b1000;
   localparam logic [3:0] condLs     = 4'b1001;
   localparam logic [3:0] condGe     = 4'b1010;
   localparam logic [3:0] condLt     = 4'b1011;
   localparam logic [3:0] condGt     = 4'b1100;
   localparam logic [3:0] condLe     = 4'b1101;
   localparam logic [3:0] condAlways = 4'b1110;

   // Bit positions in the NZCV vector
   localparam int flagN = 3;
   localparam int flagZ = 2;
   localparam int flagC = 1;
   localparam int flagV = 0;

   localparam logic [3:0] pcRegIndex = 4'd15;

endpackage

// ==== busMonitor.sv ====
`timescale 1ns/1ps

module busMonitor (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            memValid,
   input  logic                            memReady,
   input  logic [armBusPkg::addrWidth-1:0] memAddr,
   input  logic                            memWrite,
   input  logic [armBusPkg::dataWidth-1:0] memWdata,
   input  logic [armBusPkg::dataWidth-1:0] memRdata,
   input  int                              numExpected,
   output int                              matched,
   output int                              errorCount,
   output int                              extraCount,
   output logic                            done
);
   import armBusPkg::*;

   logic [dataWidth-1:0] seenData;   // Write data or read data

   initial begin
      matched    = 0;
      errorCount = 0;
      extraCount = 0;
      done       = 1'b0;
   end

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
         errorCount++;
      end
   endtask

   // One list entry per completed transfer, in order
   always @(posedge clk) begin
      if (!reset && memValid && memReady) begin
         if (matched >= numExpected) begin
            $display("Unexpected extra transfer at %0t to address %h", $time, memAddr);
            extraCount++;
         end else begin
            seenData = memWrite ? memWdata : memRdata;
            checkValue("memAddr", tbArmCore.expAddr[matched], memAddr);
            checkValue("memWrite", {31'b0, tbArmCore.expWrite[matched]}, {31'b0, memWrite});
            checkValue(memWrite ? "memWdata" : "memRdata", tbArmCore.expData[matched],
                       seenData);
            matched++;
            if (matched == numExpected)
               done = 1'b1;
         end
      end
   end

endmodule

// ==== execDatapath.sv ====
`timescale 1ns/1ps

module execDatapath (
   input  logic                            clk,
   input  logic                            reset,
   input  armIsaPkg::instrWord_u           instr,
   input  logic [armBusPkg::addrWidth-1:0] pc,
   input  logic                            retire,
   input  logic                            regWrite,
   input  logic                            aluSrcImm,
   input  logic [2:0]                      aluOp,
   input  logic [1:0]                      immSel,
   input  logic                            resultFromMem,
   input  logic [armBusPkg::dataWidth-1:0] memRdata,
   output logic [3:0]                      aluFlags,
   output logic [armBusPkg::addrWidth-1:0] dataAddrIn,
   output logic [armBusPkg::dataWidth-1:0] storeData,
   output logic [armBusPkg::addrWidth-1:0] branchTarget
);
   import armIsaPkg::*;
   import armBusPkg::*;

   logic [dataWidth-1:0]    regFile [0:14];   // R0 to R14
   logic [dataWidth-1:0]    pcPlus8;
   logic [regAddrWidth-1:0] raA, raB;
   logic [dataWidth-1:0]    srcA, regB, srcB, extImm;
   logic [dataWidth-1:0]    bOperand, aluResult, result;
   logic [dataWidth:0]      sum;                // Carry out in top bit
   logic                    subtract;

   assign pcPlus8 = pc + dataWidth'(8);

   // Branch adds its offset to R15
   assign raA = (immSel == immSelBranch) ? pcRegIndex : instr.dp.rn;
   assign raB = instr.dp.operand[regAddrWidth-1:0];

   assign srcA      = (raA == pcRegIndex) ? pcPlus8 : regFile[raA];
   assign regB      = (raB == pcRegIndex) ? pcPlus8 : regFile[raB];
   assign storeData = (instr.mem.rd == pcRegIndex) ? pcPlus8 : regFile[instr.mem.rd];

   always_comb begin
      case (immSel)
         immSel8:      extImm = {24'b0, instr.dp.operand[7:0]};
         immSel12:     extImm = {20'b0, instr.mem.imm12};
         immSelBranch: extImm = {{6{instr.br.imm24[23]}}, instr.br.imm24, 2'b00};
         default:      extImm = '0;
      endcase
   end

   assign srcB = aluSrcImm ? extImm : regB;

   // Subtract as A + ~B + 1
   assign subtract = (aluOp == aluSub);
   assign bOperand = subtract ? ~srcB : srcB;
   assign sum      = {1'b0, srcA} + {1'b0, bOperand} + (dataWidth + 1)'(subtract);

   always_comb begin
      case (aluOp)
         aluAnd:  aluResult = srcA & srcB;
         aluOrr:  aluResult = srcA | srcB;
         aluEor:  aluResult = srcA ^ srcB;
         default: aluResult = sum[dataWidth-1:0];   // aluAdd, aluSub
      endcase
   end

   always_comb begin
      aluFlags[flagN] = aluResult[dataWidth-1];
      aluFlags[flagZ] = (aluResult == '0);
      aluFlags[flagC] = sum[dataWidth];
      aluFlags[flagV] = ~(srcA[dataWidth-1] ^ bOperand[dataWidth-1]) &
                        (srcA[dataWidth-1] ^ sum[dataWidth-1]);
   end

   assign dataAddrIn   = aluResult;                 // rn + imm12
   assign result       = resultFromMem ? memRdata : aluResult;
   assign branchTarget = result;

   // Write-back on retire; rd of 15 never reaches here
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 15; i++)
            regFile[i] <= '0;
      end else if (retire && regWrite) begin
         regFile[instr.dp.rd] <= result;
      end
   end

endmodule

// ==== fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
   input  logic                            clk,
   input  logic                            reset,
   output logic                            fetchValid,
   output logic [armBusPkg::addrWidth-1:0] fetchAddr,
   input  logic                            fetchReady,
   input  logic [armBusPkg::dataWidth-1:0] memRdata,
   output armIsaPkg::instrWord_u           instr,
   output logic [armBusPkg::addrWidth-1:0] pc,
   input  logic                            memReq,
   input  logic                            dataDone,
   input  logic                            pcLoad,
   input  logic [armBusPkg::addrWidth-1:0] branchTarget,
   output logic                            retire
);
   import armBusPkg::*;

   logic                 execPhase;   // 0 = fetch, 1 = execute
   logic                 running;     // Low for one cycle after reset
   logic [addrWidth-1:0] pcNext;

   assign fetchValid = running & ~execPhase;
   assign fetchAddr  = pc;

   // Retire once any data access of this instruction is done
   assign retire = execPhase & (~memReq | dataDone);
   assign pcNext = pcLoad ? branchTarget : pc + addrWidth'(4);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         running   <= 1'b0;
         execPhase <= 1'b0;
         pc        <= '0;
         instr     <= '0;
      end else begin
         running <= 1'b1;
         if (fetchValid && fetchReady) begin
            instr     <= memRdata;    // Read data valid in transfer cycle
            execPhase <= 1'b1;
         end else if (retire) begin
            instr     <= '0;          // ANDEQ r0: no memory request while fetching
            pc        <= pcNext;
            execPhase <= 1'b0;
         end
      end
   end

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
   input  logic                  clk,
   input  logic                  reset,
   input  armIsaPkg::instrWord_u instr,
   input  logic [3:0]            aluFlags,
   input  logic                  retire,
   output logic                  regWrite,
   output logic                  memReq,
   output logic                  memStore,
   output logic                  aluSrcImm,
   output logic [2:0]            aluOp,
   output logic [1:0]            immSel,
   output logic                  resultFromMem,
   output logic                  pcLoad
);
   import armIsaPkg::*;

   logic [3:0] flags;        // NZCV
   logic       condPass;
   logic       isDp, isMem, isBranch;
   logic       writesRd;     // Before condition gating
   logic       flagWrite;
   logic       logicOp;      // AND, ORR, EOR keep C and V

   assign isDp     = (instr.dp.op == opDataProc);
   assign isMem    = (instr.mem.op == opMemory);
   assign isBranch = (instr.br.op == opBranch);

   // ALU decode
   always_comb begin
      aluOp = aluAdd;        // Address and branch target by default
      if (isDp) begin
         case (instr.dp.opcode)
            dpAdd:        aluOp = aluAdd;
            dpSub, dpCmp: aluOp = aluSub;
            dpAnd:        aluOp = aluAnd;
            dpOrr:        aluOp = aluOrr;
            dpEor:        aluOp = aluEor;
            default:      aluOp = aluAdd;
         endcase
      end
   end

   assign logicOp   = (aluOp == aluAnd) | (aluOp == aluOrr) | (aluOp == aluEor);
   assign writesRd  = (isDp & (instr.dp.opcode != dpCmp)) | (isMem & instr.mem.load);
   assign flagWrite = isDp & (instr.dp.sBit | (instr.dp.opcode == dpCmp)) & condPass;

   always_comb begin
      case (instr.dp.cond)
         condEq:     condPass = flags[flagZ];
         condNe:     condPass = ~flags[flagZ];
         condCs:     condPass = flags[flagC];
         condCc:     condPass = ~flags[flagC];
         condMi:     condPass = flags[flagN];
         condPl:     condPass = ~flags[flagN];
         condVs:     condPass = flags[flagV];
         condVc:     condPass = ~flags[flagV];
         condHi:     condPass = flags[flagC] & ~flags[flagZ];
         condLs:     condPass = ~flags[flagC] | flags[flagZ];
         condGe:     condPass = (flags[flagN] == flags[flagV]);
         condLt:     condPass = (flags[flagN] != flags[flagV]);
         condGt:     condPass = ~flags[flagZ] & (flags[flagN] == flags[flagV]);
         condLe:     condPass = flags[flagZ] | (flags[flagN] != flags[flagV]);
         condAlways: condPass = 1'b1;
         default:    condPass = 1'b0;   // 1111 never executes
      endcase
   end

   // R15 is the PC, not a register file entry
   assign regWrite = writesRd & condPass & (instr.dp.rd != pcRegIndex);
   assign pcLoad   = condPass & (isBranch |
                     (isDp & writesRd & (instr.dp.rd == pcRegIndex)));
   assign memReq   = isMem & condPass;
   assign memStore = ~instr.mem.load;

   assign aluSrcImm     = isDp ? instr.dp.immFlag : 1'b1;
   assign immSel        = isMem ? immSel12 : (isBranch ? immSelBranch : immSel8);
   assign resultFromMem = isMem;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else if (retire && flagWrite) begin
         flags[flagN] <= aluFlags[flagN];
         flags[flagZ] <= aluFlags[flagZ];
         if (!logicOp) begin
            flags[flagC] <= aluFlags[flagC];
            flags[flagV] <= aluFlags[flagV];
         end
      end
   end

endmodule

// ==== list.f ====
armIsaPkg.sv
armBusPkg.sv
fetchUnit.sv
loadStoreUnit.sv
memArbiter.sv
instrDecoder.sv
execDatapath.sv
armCore.sv
armCore_assertions.sv
busMonitor.sv
tbArmCore.sv

// ==== loadStoreUnit.sv ====
`timescale 1ns/1ps

module loadStoreUnit (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            memReq,
   input  logic                            memStore,
   input  logic [armBusPkg::addrWidth-1:0] dataAddrIn,
   input  logic [armBusPkg::dataWidth-1:0] storeData,
   output logic                            dataValid,
   output logic [armBusPkg::addrWidth-1:0] dataAddr,
   output logic                            dataWrite,
   output logic [armBusPkg::dataWidth-1:0] dataWdata,
   input  logic                            dataReady,
   output logic                            dataDone
);

   logic doneFlag;   // Access of this execute phase already made
   logic issue;

   assign issue    = memReq & ~dataValid & ~doneFlag;
   assign dataDone = dataValid & dataReady;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         dataValid <= 1'b0;
         dataWrite <= 1'b0;
         doneFlag  <= 1'b0;
      end else begin
         if (dataDone) begin
            dataValid <= 1'b0;
            doneFlag  <= 1'b1;
         end else if (issue) begin
            dataValid <= 1'b1;
            dataWrite <= memStore;
         end
         if (!memReq)
            doneFlag <= 1'b0;     // Rearm for the next instruction
      end
   end

   // Request fields latched once, stable under back-pressure
   always_ff @(posedge clk) begin
      if (issue) begin
         dataAddr  <= dataAddrIn;
         dataWdata <= storeData;
      end
   end

endmodule

// ==== memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            fetchValid,
   input  logic [armBusPkg::addrWidth-1:0] fetchAddr,
   input  logic                            dataValid,
   input  logic [armBusPkg::addrWidth-1:0] dataAddr,
   input  logic                            dataWrite,
   input  logic [armBusPkg::dataWidth-1:0] dataWdata,
   output logic                            fetchReady,
   output logic                            dataReady,
   output logic                            memValid,
   input  logic                            memReady,
   output logic [armBusPkg::addrWidth-1:0] memAddr,
   output logic                            memWrite,
   output logic [armBusPkg::dataWidth-1:0] memWdata
);
   import armBusPkg::*;

   logic                  busy;    // Grant locked, transfer pending
   logic [reqIdWidth-1:0] owner;
   logic [reqIdWidth-1:0] grant;
   logic                  dataSel;

   // Data first when idle, otherwise keep the locked owner
   always_comb begin
      if (busy)
         grant = owner;
      else if (dataValid)
         grant = reqIdWidth'(reqData);
      else
         grant = reqIdWidth'(reqFetch);
   end

   assign dataSel  = (grant == reqIdWidth'(reqData));
   assign memValid = dataSel ? dataValid : fetchValid;
   assign memAddr  = dataSel ? dataAddr : fetchAddr;
   assign memWrite = dataSel & dataWrite;      // Fetches always read
   assign memWdata = dataSel ? dataWdata : '0;

   assign dataReady  = dataSel & memReady;
   assign fetchReady = ~dataSel & memReady;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         busy  <= 1'b0;
         owner <= reqIdWidth'(reqFetch);
      end else if (memValid && !memReady) begin
         busy  <= 1'b1;
         owner <= grant;
      end else if (memValid && memReady) begin
         busy <= 1'b0;          // Released on transfer
      end
   end

endmodule

// ==== tbArmCore.sv ====
`timescale 1ns/1ps

module tbArmCore;
   import armBusPkg::*;

   localparam int memWords  = 256;             // 1 KB model aliased through the address space
   localparam int maxTokens = 512;

   logic                 clk;
   logic                 reset;
   logic                 memValid, memReady, memWrite;
   logic [addrWidth-1:0] memAddr;
   logic [dataWidth-1:0] memWdata, memRdata;

   logic [31:0]          stimWords [0:maxTokens-1];
   logic [dataWidth-1:0] memory    [0:memWords-1];
   logic [addrWidth-1:0] expAddr   [0:maxTokens-1];   // Read by busMonitor
   logic                 expWrite  [0:maxTokens-1];
   logic [dataWidth-1:0] expData   [0:maxTokens-1];

   int          numExpected;
   int          cycles, timeoutLimit, waitLeft;
   int          matched, errorCount, extraCount, missingCount, assertFails;
   logic        monitorDone;
   logic        timedOut;
   logic [31:0] rngState;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   armCore i_armCore (
      .clk(clk), .reset(reset),
      .memValid(memValid), .memReady(memReady), .memAddr(memAddr),
      .memWrite(memWrite), .memWdata(memWdata), .memRdata(memRdata));

   bind armCore armCore_assertions i_armCoreAssertions (
      .clk(clk), .reset(reset), .memValid(memValid), .memReady(memReady),
      .memAddr(memAddr), .memWrite(memWrite), .memWdata(memWdata));

   busMonitor i_busMonitor (
      .clk(clk), .reset(reset), .memValid(memValid), .memReady(memReady),
      .memAddr(memAddr), .memWrite(memWrite), .memWdata(memWdata),
      .memRdata(memRdata), .numExpected(numExpected), .matched(matched),
      .errorCount(errorCount), .extraCount(extraCount), .done(monitorDone));

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;     // 4 ns period
   end

   assign memRdata = memory[memAddr[9:2]];   // Read data in transfer cycle

   always @(posedge clk) begin
      if (memValid && memReady && memWrite)
         memory[memAddr[9:2]] <= memWdata;
   end

   // Random wait states of 0 to 3 cycles before each transfer
   always @(posedge clk) begin
      if (!reset && memValid) begin
         if (memReady) begin
            rngState = xorshift(rngState);
            waitLeft = rngState % 4;
         end else if (waitLeft > 0) begin
            waitLeft = waitLeft - 1;
         end
         memReady <= (waitLeft == 0);
      end
   end

   initial begin
      reset       = 1'b1;
      memReady    = 1'b0;
      rngState    = 32'd81104;
      waitLeft    = 0;
      numExpected = 0;
      timedOut    = 1'b0;
      for (int i = 0; i < memWords; i++)
         memory[i] = 32'hBAD00000 | (i << 2);    // Fill from full address
      for (int i = 0; i < maxTokens; i++)
         stimWords[i] = '0;
      $readmemh("armCore_stimulus.txt", stimWords);
      // Four words per record as kind, address, write flag and data
      for (int r = 0; r + 3 < maxTokens; r += 4) begin
         case (stimWords[r])
            32'd1, 32'd2: memory[stimWords[r+1][9:2]] = stimWords[r+3];
            32'd3: begin
               expAddr[numExpected]  = stimWords[r+1];
               expWrite[numExpected] = stimWords[r+2][0];
               expData[numExpected]  = stimWords[r+3];
               numExpected++;
            end
            default: ;
         endcase
      end
      timeoutLimit = numExpected * 5 + 50;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      cycles = 0;
      // Falling edge sees the monitor and assertions of the last rising edge
      while (!monitorDone && cycles < timeoutLimit) begin
         @(negedge clk);
         cycles++;
      end
      if (!monitorDone) begin
         timedOut = 1'b1;
         $display("Timeout after %0d cycles, expected transfers never arrived", cycles);
      end
      missingCount = numExpected - matched;
      assertFails  = i_armCore.i_armCoreAssertions.failCount;
      $display("Errors: %0d wrong values, %0d missing, %0d extra, %0d assertion failures",
               errorCount, missingCount, extraCount, assertFails);
      if (!timedOut && errorCount == 0 && missingCount == 0 && extraCount == 0 &&
          assertFails == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
